// File: project.f
hdl/csr_pkg.sv
hdl/csr_exception.sv
hdl/csr_timer.sv
hdl/csr_interrupt.sv
hdl/csr_save_regs.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
bench/csr_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := csr_tb
FILELIST   := project.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;
    localparam int CLK_PERIOD = 20;
    // all tests together take under 200 cycles
    localparam int WATCHDOG_CYCLES = 3000;

    logic                            clk;
    logic                            reset;
    logic [csr_pkg::CSR_ADDR_W-1:0]  csr_raddr;
    logic                            csr_wr_en;
    logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr;
    logic [csr_pkg::CSR_DATA_W-1:0]  csr_wdata;
    logic                            excp_flush;
    logic                            ertn_flush;
    logic                            excp_tlbrefill;
    logic [csr_pkg::ECODE_W-1:0]     ecode_in;
    logic [csr_pkg::ESUBCODE_W-1:0]  esubcode_in;
    logic [csr_pkg::CSR_DATA_W-1:0]  era_in;
    logic                            error_va_en;
    logic [csr_pkg::CSR_DATA_W-1:0]  error_vaddr;
    logic [csr_pkg::HWI_W-1:0]       interrupt;
    logic [csr_pkg::CSR_DATA_W-1:0]  csr_rdata;
    logic [csr_pkg::CSR_DATA_W-1:0]  eentry_out;
    logic [csr_pkg::CSR_DATA_W-1:0]  era_out;
    csr_pkg::plv_t                   plv_out;
    logic                            has_int;
    integer                          seed;

    csr_unit DUT (
        .clk(clk), .reset(reset), .csr_raddr(csr_raddr),
        .csr_wr_en(csr_wr_en), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush),
        .excp_tlbrefill(excp_tlbrefill),
        .ecode_in(ecode_in), .esubcode_in(esubcode_in), .era_in(era_in),
        .error_va_en(error_va_en), .error_vaddr(error_vaddr), .interrupt(interrupt),
        .csr_rdata(csr_rdata), .eentry_out(eentry_out), .era_out(era_out),
        .plv_out(plv_out), .has_int(has_int)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    // inputs change 1 ns after the edge
    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, got, want);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic write_csr(input logic [13:0] addr, input logic [31:0] data);
        csr_wr_en = 1'b1;
        csr_waddr = addr;
        csr_wdata = data;
        step;
        csr_wr_en = 1'b0;
    endtask

    task automatic expect_csr(input logic [13:0] addr, input logic [31:0] want,
                              input string name);
        csr_raddr = addr;
        #2;
        check(name, csr_rdata, want);
    endtask

    task automatic expect_has_int(input logic want);
        #2;
        check("has_int", 32'(has_int), 32'(want));
    endtask

    task automatic wait_for_has_int(input int max_cycles);
        int n;
        n = 0;
        #1;
        while (!has_int && n < max_cycles) begin
            step;
            n++;
        end
        assert (has_int) else begin
            $display("timeout: has_int did not rise within %0d cycles", max_cycles);
            $display("Test failures found");
            $fatal(1, "interrupt never raised");
        end
    endtask

    task automatic test_reset_and_save;
        logic [31:0] vals [4];
        logic [31:0] fwd;
        expect_csr(csr_pkg::CRMD, 32'h8, "CRMD");
        expect_has_int(1'b0);
        for (int i = 0; i < 4; i++) begin
            vals[i] = $random(seed);
            write_csr(14'(csr_pkg::SAVE0 + i), vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            expect_csr(14'(csr_pkg::SAVE0 + i), vals[i], $sformatf("SAVE%0d", i));
        end
        // read of the address being written sees the new data
        fwd = $random(seed);
        csr_raddr = csr_pkg::SAVE2;
        csr_wr_en = 1'b1;
        csr_waddr = csr_pkg::SAVE2;
        csr_wdata = fwd;
        #2;
        check("csr_rdata forwarded", csr_rdata, fwd);
        step;
        csr_wr_en = 1'b0;
        expect_csr(csr_pkg::SAVE2, fwd, "SAVE2");
    endtask

    task automatic test_exception_return;
        write_csr(csr_pkg::CRMD, 32'h0000_000f);
        write_csr(csr_pkg::EENTRY, 32'h1c00_0abc);
        excp_flush = 1'b1;
        ecode_in = 6'h0c;
        esubcode_in = 9'h005;
        era_in = 32'h1c00_1234;
        #2;
        check("plv_out", 32'(plv_out), 32'h0);
        step;
        excp_flush = 1'b0;
        expect_csr(csr_pkg::CRMD, 32'h8, "CRMD");
        expect_csr(csr_pkg::PRMD, 32'h7, "PRMD");
        expect_csr(csr_pkg::ERA, 32'h1c00_1234, "ERA");
        expect_csr(csr_pkg::ESTAT, (32'h005 << 22) | (32'h0c << 16), "ESTAT");
        check("eentry_out", eentry_out, 32'h1c00_0a80);
        check("era_out", era_out, 32'h1c00_1234);
        ertn_flush = 1'b1;
        #2;
        check("plv_out", 32'(plv_out), 32'h3);
        step;
        ertn_flush = 1'b0;
        expect_csr(csr_pkg::CRMD, 32'hf, "CRMD");
    endtask

    task automatic test_tlb_refill;
        // paged mode first so the switch to DA is visible
        write_csr(csr_pkg::CRMD, 32'h17);
        excp_flush = 1'b1;
        excp_tlbrefill = 1'b1;
        ecode_in = 6'h3f;
        esubcode_in = 9'h0;
        era_in = 32'h1c00_2000;
        step;
        excp_flush = 1'b0;
        excp_tlbrefill = 1'b0;
        // return must depend on the recorded code only
        ecode_in = 6'h00;
        expect_csr(csr_pkg::CRMD, 32'h8, "CRMD");
        ertn_flush = 1'b1;
        step;
        ertn_flush = 1'b0;
        expect_csr(csr_pkg::CRMD, 32'h17, "CRMD");
    endtask

    task automatic test_timer;
        write_csr(csr_pkg::CRMD, 32'h17);
        write_csr(csr_pkg::ECFG, 32'h800);
        // initial value 5, enabled, one-shot
        write_csr(csr_pkg::TCFG, (32'd5 << 2) | 32'h1);
        for (int k = 0; k <= 20; k++) begin
            expect_csr(csr_pkg::TVAL, 32'(20 - k), "TVAL");
            expect_has_int(1'b0);
            step;
        end
        wait_for_has_int(4);
        expect_csr(csr_pkg::TVAL, 32'hffff_ffff, "TVAL");
        write_csr(csr_pkg::TICLR, 32'h1);
        expect_has_int(1'b0);
        expect_csr(csr_pkg::TVAL, 32'hffff_ffff, "TVAL");
    endtask

    task automatic test_external_irq;
        interrupt = 8'h08;
        step;
        csr_raddr = csr_pkg::ESTAT;
        #2;
        check("ESTAT[9:2]", 32'(csr_rdata[9:2]), 32'h08);
        expect_has_int(1'b0);
        write_csr(csr_pkg::ECFG, 32'h20);
        expect_has_int(1'b1);
        write_csr(csr_pkg::CRMD, 32'h13);
        expect_has_int(1'b0);
        write_csr(csr_pkg::CRMD, 32'h17);
        expect_has_int(1'b1);
        write_csr(csr_pkg::ECFG, 32'h0);
        expect_has_int(1'b0);
        interrupt = 8'h00;
        step;
        csr_raddr = csr_pkg::ESTAT;
        #2;
        check("ESTAT[9:2]", 32'(csr_rdata[9:2]), 32'h00);
    endtask

    task automatic test_badv;
        error_va_en = 1'b1;
        error_vaddr = 32'hdead_beef;
        step;
        error_va_en = 1'b0;
        expect_csr(csr_pkg::BADV, 32'hdead_beef, "BADV");
        // software write beats the hardware capture
        error_va_en = 1'b1;
        error_vaddr = 32'h1111_2222;
        write_csr(csr_pkg::BADV, 32'h3333_4444);
        error_va_en = 1'b0;
        expect_csr(csr_pkg::BADV, 32'h3333_4444, "BADV");
    endtask

    initial begin
        seed = 79517;
        clk = 1'b0;
        reset = 1'b1;
        csr_raddr = '0;
        csr_wr_en = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        excp_tlbrefill = 1'b0;
        ecode_in = '0;
        esubcode_in = '0;
        era_in = '0;
        error_va_en = 1'b0;
        error_vaddr = '0;
        interrupt = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_and_save;
        test_exception_return;
        test_tlb_refill;
        test_timer;
        test_external_irq;
        test_badv;
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: hdl/csr_unit.sv
`timescale 1ns/1ns

module csr_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_raddr,
    input  logic                            csr_wr_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  csr_wdata,
    input  logic                            excp_flush,
    input  logic                            ertn_flush,
    input  logic                            excp_tlbrefill,
    input  logic [csr_pkg::ECODE_W-1:0]     ecode_in,
    input  logic [csr_pkg::ESUBCODE_W-1:0]  esubcode_in,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  era_in,
    input  logic                            error_va_en,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  error_vaddr,
    input  logic [csr_pkg::HWI_W-1:0]       interrupt,
    output logic [csr_pkg::CSR_DATA_W-1:0]  csr_rdata,
    output logic [csr_pkg::CSR_DATA_W-1:0]  eentry_out,
    output logic [csr_pkg::CSR_DATA_W-1:0]  era_out,
    output csr_pkg::plv_t                   plv_out,
    output logic                            has_int
);
    logic [csr_pkg::CSR_DATA_W-1:0] crmd;
    logic [csr_pkg::CSR_DATA_W-1:0] prmd;
    logic [csr_pkg::CSR_DATA_W-1:0] badv;
    logic [csr_pkg::ECODE_W-1:0]    ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] esubcode;
    logic                           ie;
    logic [csr_pkg::CSR_DATA_W-1:0] ecfg;
    logic [csr_pkg::INT_W-1:0]      int_status;
    logic [csr_pkg::CSR_DATA_W-1:0] tid;
    logic [csr_pkg::CSR_DATA_W-1:0] tcfg;
    logic [csr_pkg::CSR_DATA_W-1:0] tval;
    logic                           timer_irq;
    logic [csr_pkg::CSR_DATA_W-1:0] save0;
    logic [csr_pkg::CSR_DATA_W-1:0] save1;
    logic [csr_pkg::CSR_DATA_W-1:0] save2;
    logic [csr_pkg::CSR_DATA_W-1:0] save3;

    csr_exception u_exception (
        .clk(clk), .reset(reset),
        .csr_wr_en(csr_wr_en), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush),
        .excp_tlbrefill(excp_tlbrefill),
        .ecode_in(ecode_in), .esubcode_in(esubcode_in), .era_in(era_in),
        .error_va_en(error_va_en), .error_vaddr(error_vaddr),
        .crmd(crmd), .prmd(prmd), .era(era_out), .eentry(eentry_out),
        .badv(badv), .ecode(ecode), .esubcode(esubcode),
        .ie(ie), .plv_out(plv_out)
    );

    csr_timer u_timer (
        .clk(clk), .reset(reset),
        .csr_wr_en(csr_wr_en), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .tid(tid), .tcfg(tcfg), .tval(tval), .timer_irq(timer_irq)
    );

    csr_interrupt u_interrupt (
        .clk(clk), .reset(reset),
        .csr_wr_en(csr_wr_en), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .interrupt(interrupt), .timer_irq(timer_irq), .ie(ie),
        .ecfg(ecfg), .int_status(int_status), .has_int(has_int)
    );

    csr_save_regs u_save_regs (
        .clk(clk),
        .csr_wr_en(csr_wr_en), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3)
    );

    csr_read_mux u_read_mux (
        .csr_raddr(csr_raddr),
        .csr_wr_en(csr_wr_en), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .int_status(int_status),
        .ecode(ecode), .esubcode(esubcode),
        .era(era_out), .badv(badv), .eentry(eentry_out),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(tid), .tcfg(tcfg), .tval(tval),
        .csr_rdata(csr_rdata)
    );

endmodule

// File: hdl/csr_read_mux.sv
`timescale 1ns/1ns

module csr_read_mux (
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_raddr,
    input  logic                            csr_wr_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  csr_wdata,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  crmd,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  prmd,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  ecfg,
    input  logic [csr_pkg::INT_W-1:0]       int_status,
    input  logic [csr_pkg::ECODE_W-1:0]     ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]  esubcode,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  era,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  badv,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  eentry,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  save0,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  save1,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  save2,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  save3,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  tid,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  tcfg,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  tval,
    output logic [csr_pkg::CSR_DATA_W-1:0]  csr_rdata
);
    logic [csr_pkg::CSR_DATA_W-1:0] estat;
    logic [csr_pkg::CSR_DATA_W-1:0] stored;

    always_comb begin
        estat = '0;
        estat[csr_pkg::INT_W-1:0] = int_status;
        estat[csr_pkg::ECODE_LSB +: csr_pkg::ECODE_W] = ecode;
        estat[csr_pkg::ESUBCODE_LSB +: csr_pkg::ESUBCODE_W] = esubcode;
    end

    always_comb begin
        case (csr_pkg::csr_addr_e'(csr_raddr))
            csr_pkg::CRMD:   stored = crmd;
            csr_pkg::PRMD:   stored = prmd;
            csr_pkg::ECFG:   stored = ecfg;
            csr_pkg::ESTAT:  stored = estat;
            csr_pkg::ERA:    stored = era;
            csr_pkg::BADV:   stored = badv;
            csr_pkg::EENTRY: stored = eentry;
            csr_pkg::SAVE0:  stored = save0;
            csr_pkg::SAVE1:  stored = save1;
            csr_pkg::SAVE2:  stored = save2;
            csr_pkg::SAVE3:  stored = save3;
            csr_pkg::TID:    stored = tid;
            csr_pkg::TCFG:   stored = tcfg;
            csr_pkg::TVAL:   stored = tval;
            // ticlr is write-only
            csr_pkg::TICLR:  stored = '0;
            default:         stored = '0;
        endcase
    end

    // same-cycle write shows up on the read port
    assign csr_rdata = (csr_wr_en && (csr_waddr == csr_raddr)) ? csr_wdata : stored;

endmodule

// File: hdl/csr_save_regs.sv
`timescale 1ns/1ns

module csr_save_regs (
    input  logic                            clk,
    input  logic                            csr_wr_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  csr_wdata,
    output logic [csr_pkg::CSR_DATA_W-1:0]  save0,
    output logic [csr_pkg::CSR_DATA_W-1:0]  save1,
    output logic [csr_pkg::CSR_DATA_W-1:0]  save2,
    output logic [csr_pkg::CSR_DATA_W-1:0]  save3
);
    // scratch space for the exception handler
    always_ff @(posedge clk) begin
        if (csr_wr_en) begin
            case (csr_waddr)
                csr_pkg::SAVE0: save0 <= csr_wdata;
                csr_pkg::SAVE1: save1 <= csr_wdata;
                csr_pkg::SAVE2: save2 <= csr_wdata;
                csr_pkg::SAVE3: save3 <= csr_wdata;
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/csr_interrupt.sv
`timescale 1ns/1ns

module csr_interrupt (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            csr_wr_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  csr_wdata,
    input  logic [csr_pkg::HWI_W-1:0]       interrupt,
    input  logic                            timer_irq,
    input  logic                            ie,
    output logic [csr_pkg::CSR_DATA_W-1:0]  ecfg,
    output logic [csr_pkg::INT_W-1:0]       int_status,
    output logic                            has_int
);
    logic ecfg_wen;
    logic estat_wen;
    logic [csr_pkg::INT_W-1:0]   lie;
    logic [csr_pkg::HWI_LSB-1:0] swi;
    logic [csr_pkg::HWI_W-1:0]   hwi;

    assign ecfg_wen  = csr_wr_en && (csr_waddr == csr_pkg::ECFG);
    assign estat_wen = csr_wr_en && (csr_waddr == csr_pkg::ESTAT);

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
            swi <= '0;
            hwi <= '0;
        end else begin
            if (ecfg_wen) begin
                lie <= csr_wdata[csr_pkg::INT_W-1:0];
            end
            // software interrupts live in the low estat bits
            if (estat_wen) begin
                swi <= csr_wdata[csr_pkg::HWI_LSB-1:0];
            end
            hwi <= interrupt;
        end
    end

    always_comb begin
        int_status = '0;
        int_status[csr_pkg::HWI_LSB-1:0] = swi;
        int_status[csr_pkg::HWI_LSB +: csr_pkg::HWI_W] = hwi;
        int_status[csr_pkg::TI_BIT] = timer_irq;
    end

    assign ecfg    = {{(csr_pkg::CSR_DATA_W-csr_pkg::INT_W){1'b0}}, lie};
    assign has_int = (|(int_status & lie)) && ie;

endmodule

// File: hdl/csr_timer.sv
`timescale 1ns/1ns

module csr_timer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            csr_wr_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_waddr,
    input  logic [csr_pkg::CSR_DATA_W-1:0]  csr_wdata,
    output logic [csr_pkg::CSR_DATA_W-1:0]  tid,
    output logic [csr_pkg::CSR_DATA_W-1:0]  tcfg,
    output logic [csr_pkg::CSR_DATA_W-1:0]  tval,
    output logic                            timer_irq
);
    localparam int IL = csr_pkg::INITVAL_LSB;
    localparam int IW = csr_pkg::INITVAL_W;

    logic tid_wen;
    logic tcfg_wen;
    logic ticlr_wen;
    logic periodic;
    logic expire;

    assign tid_wen   = csr_wr_en && (csr_waddr == csr_pkg::TID);
    assign tcfg_wen  = csr_wr_en && (csr_waddr == csr_pkg::TCFG);
    assign ticlr_wen = csr_wr_en && (csr_waddr == csr_pkg::TICLR)
                       && csr_wdata[csr_pkg::TICLR_CLR_BIT];
    assign periodic  = tcfg[csr_pkg::TCFG_PERIODIC_BIT];
    assign expire    = tcfg[csr_pkg::TCFG_EN_BIT] && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (tid_wen) begin
            tid <= csr_wdata;
        end
    end

    // one-shot mode turns itself off on expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (tcfg_wen) begin
            tcfg[csr_pkg::TCFG_EN_BIT]       <= csr_wdata[csr_pkg::TCFG_EN_BIT];
            tcfg[csr_pkg::TCFG_PERIODIC_BIT] <= csr_wdata[csr_pkg::TCFG_PERIODIC_BIT];
            tcfg[IL +: IW]                   <= csr_wdata[IL +: IW];
        end else if (expire && !periodic) begin
            tcfg[csr_pkg::TCFG_EN_BIT] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '0;
        end else if (tcfg_wen) begin
            tval <= {csr_wdata[IL +: IW], 2'b00};
        end else if (expire) begin
            tval <= periodic ? {tcfg[IL +: IW], 2'b00} : csr_pkg::TVAL_ONESHOT;
        end else if (tcfg[csr_pkg::TCFG_EN_BIT]) begin
            tval <= tval - 1'b1;
        end
    end

    // expiry beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else if (expire) begin
            timer_irq <= 1'b1;
        end else if (ticlr_wen) begin
            timer_irq <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !tcfg[csr_pkg::TCFG_EN_BIT] && !tcfg_wen |=> $stable(tval));

endmodule

// File: hdl/csr_exception.sv
`timescale 1ns/1ns

module csr_exception (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             csr_wr_en,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   csr_waddr,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wdata,
    input  logic                             excp_flush,
    input  logic                             ertn_flush,
    input  logic                             excp_tlbrefill,
    input  logic [csr_pkg::ECODE_W-1:0]      ecode_in,
    input  logic [csr_pkg::ESUBCODE_W-1:0]   esubcode_in,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   era_in,
    input  logic                             error_va_en,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   error_vaddr,
    output logic [csr_pkg::CSR_DATA_W-1:0]   crmd,
    output logic [csr_pkg::CSR_DATA_W-1:0]   prmd,
    output logic [csr_pkg::CSR_DATA_W-1:0]   era,
    output logic [csr_pkg::CSR_DATA_W-1:0]   eentry,
    output logic [csr_pkg::CSR_DATA_W-1:0]   badv,
    output logic [csr_pkg::ECODE_W-1:0]      ecode,
    output logic [csr_pkg::ESUBCODE_W-1:0]   esubcode,
    output logic                             ie,
    output csr_pkg::plv_t                    plv_out
);
    localparam int PL = csr_pkg::PLV_LSB;
    localparam int PW = csr_pkg::PLV_W;

    logic crmd_wen;
    logic prmd_wen;
    logic era_wen;
    logic eentry_wen;
    logic badv_wen;
    logic ertn_tlbr;
    logic [csr_pkg::CSR_DATA_W-csr_pkg::EENTRY_LSB-1:0] eentry_va;

    assign crmd_wen   = csr_wr_en && (csr_waddr == csr_pkg::CRMD);
    assign prmd_wen   = csr_wr_en && (csr_waddr == csr_pkg::PRMD);
    assign era_wen    = csr_wr_en && (csr_waddr == csr_pkg::ERA);
    assign eentry_wen = csr_wr_en && (csr_waddr == csr_pkg::EENTRY);
    assign badv_wen   = csr_wr_en && (csr_waddr == csr_pkg::BADV);
    // leaving a refill handler goes back to paged mode
    assign ertn_tlbr  = ertn_flush && (ecode == csr_pkg::ECODE_TLBR);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= csr_pkg::CRMD_RESET;
        end else if (excp_flush) begin
            crmd[PL +: PW] <= '0;
            crmd[csr_pkg::IE_BIT] <= 1'b0;
            if (excp_tlbrefill) begin
                crmd[csr_pkg::DA_BIT] <= 1'b1;
                crmd[csr_pkg::PG_BIT] <= 1'b0;
            end
        end else if (ertn_flush) begin
            crmd[PL +: PW] <= prmd[PL +: PW];
            crmd[csr_pkg::IE_BIT] <= prmd[csr_pkg::IE_BIT];
            if (ertn_tlbr) begin
                crmd[csr_pkg::DA_BIT] <= 1'b0;
                crmd[csr_pkg::PG_BIT] <= 1'b1;
            end
        end else if (crmd_wen) begin
            crmd[PL +: PW] <= csr_wdata[PL +: PW];
            crmd[csr_pkg::IE_BIT] <= csr_wdata[csr_pkg::IE_BIT];
            crmd[csr_pkg::DA_BIT] <= csr_wdata[csr_pkg::DA_BIT];
            crmd[csr_pkg::PG_BIT] <= csr_wdata[csr_pkg::PG_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd[PL +: PW] <= crmd[PL +: PW];
            prmd[csr_pkg::IE_BIT] <= crmd[csr_pkg::IE_BIT];
        end else if (prmd_wen) begin
            prmd[PL +: PW] <= csr_wdata[PL +: PW];
            prmd[csr_pkg::IE_BIT] <= csr_wdata[csr_pkg::IE_BIT];
        end
    end

    // cause code only comes from hardware
    always_ff @(posedge clk) begin
        if (reset) begin
            ecode    <= '0;
            esubcode <= '0;
        end else if (excp_flush) begin
            ecode    <= ecode_in;
            esubcode <= esubcode_in;
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era <= era_in;
        end else if (era_wen) begin
            era <= csr_wdata;
        end
        if (eentry_wen) begin
            eentry_va <= csr_wdata[csr_pkg::CSR_DATA_W-1:csr_pkg::EENTRY_LSB];
        end
        if (badv_wen) begin
            badv <= csr_wdata;
        end else if (error_va_en) begin
            badv <= error_vaddr;
        end
    end

    assign eentry = {eentry_va, {csr_pkg::EENTRY_LSB{1'b0}}};
    assign ie     = crmd[csr_pkg::IE_BIT];

    // level crmd will hold after this edge
    always_comb begin
        if (excp_flush) begin
            plv_out = '0;
        end else if (ertn_flush) begin
            plv_out = prmd[PL +: PW];
        end else if (crmd_wen) begin
            plv_out = csr_wdata[PL +: PW];
        end else begin
            plv_out = crmd[PL +: PW];
        end
    end

    // pipeline flushes one cause at a time
    assert property (@(posedge clk) disable iff (reset) !(excp_flush && ertn_flush));

endmodule

// File: hdl/csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        BADV   = 14'h007,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_addr_e;

    // mode fields of crmd and prmd
    localparam int PLV_LSB = 0;
    localparam int PLV_W   = 2;
    localparam int IE_BIT  = 2;
    localparam int DA_BIT  = 3;
    localparam int PG_BIT  = 4;

    localparam int ECODE_LSB    = 16;
    localparam int ECODE_W      = 6;
    localparam int ESUBCODE_LSB = 22;
    localparam int ESUBCODE_W   = 9;
    localparam logic [ECODE_W-1:0] ECODE_TLBR = 6'h3f;

    localparam int INT_W   = 13;
    localparam int HWI_LSB = 2;
    localparam int HWI_W   = 8;
    localparam int TI_BIT  = 11;

    localparam int EENTRY_LSB = 6;

    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int INITVAL_LSB       = 2;
    localparam int INITVAL_W         = 30;
    localparam int TICLR_CLR_BIT     = 0;

    typedef logic [PLV_W-1:0] plv_t;

    // direct address mode out of reset
    localparam logic [CSR_DATA_W-1:0] CRMD_RESET   = CSR_DATA_W'(1) << DA_BIT;
    localparam logic [CSR_DATA_W-1:0] TVAL_ONESHOT = '1;

endpackage
